/* rtl/csr_pkg.sv */
package csr_pkg;

  // widths --------------
  localparam int xlen       = 32;
  localparam int csr_addr_w = 12;

  // machine-mode csr addresses.
  localparam logic [csr_addr_w-1:0] csr_mstatus   = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec     = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc      = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause    = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mvendorid = 12'hf11;
  localparam logic [csr_addr_w-1:0] csr_marchid   = 12'hf12;

  // instruction encodings --------------
  localparam logic [6:0] opcode_system = 7'b1110011;

  // both trap instructions are fixed words.
  localparam logic [31:0] insn_ecall = 32'h0000_0073;
  localparam logic [31:0] insn_mret  = 32'h3020_0073;

  // mstatus fields --------------
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;

  // mpp is hardwired to machine mode.
  localparam logic [xlen-1:0] mstatus_mpp_m = 32'h0000_1800;

  // only mie and mpie hold state.
  localparam logic [xlen-1:0] mstatus_wmask =
    (xlen'(1) << mstatus_mie_bit) | (xlen'(1) << mstatus_mpie_bit);

  // environment call from m-mode.
  localparam logic [xlen-1:0] mcause_ecall_m = 32'd11;

  // operations --------------
  typedef enum logic [2:0] {
    op_none,
    op_rw,
    op_set,
    op_clear,
    op_ecall,
    op_mret
  } csr_op_e;

endpackage

/* rtl/csr_decode.sv */
`timescale 1ns/1ps

module csr_decode (
  input  logic                            instr_valid,
  input  logic [31:0]                     instr,
  input  logic [csr_pkg::xlen-1:0]        rs1_data,
  output csr_pkg::csr_op_e                op,
  output logic [csr_pkg::xlen-1:0]        operand,
  output logic [csr_pkg::csr_addr_w-1:0]  csr_addr,
  output logic [4:0]                      rd_addr,
  output logic                            wr_en
);

  // low funct3 bits, shared by register and immediate forms.
  localparam logic [1:0] f3_rw    = 2'b01;
  localparam logic [1:0] f3_set   = 2'b10;
  localparam logic [1:0] f3_clear = 2'b11;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rs1_field;
  logic       is_system;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign rs1_field = instr[19:15];
  assign is_system = instr_valid && (opcode == csr_pkg::opcode_system);

  assign csr_addr = instr[31:20];
  assign rd_addr  = instr[11:7];

  // immediate forms carry zimm in the rs1 field.
  assign operand = funct3[2] ? {{(csr_pkg::xlen-5){1'b0}}, rs1_field} : rs1_data;

  // operation select --------------
  always_comb begin
    op = csr_pkg::op_none;
    if (is_system) begin
      case (funct3[1:0])
        f3_rw:    op = csr_pkg::op_rw;
        f3_set:   op = csr_pkg::op_set;
        f3_clear: op = csr_pkg::op_clear;
        default: begin
          // funct3 100 is reserved.
          if (funct3 == 3'b000) begin
            if (instr == csr_pkg::insn_ecall) begin
              op = csr_pkg::op_ecall;
            end else if (instr == csr_pkg::insn_mret) begin
              op = csr_pkg::op_mret;
            end
          end
        end
      endcase
    end
    if (!instr_valid) begin
      assert (op == csr_pkg::op_none)
        else $error("csr_decode: operation decoded without instr_valid");
    end
  end

  // write decision --------------
  always_comb begin
    case (op)
      csr_pkg::op_rw: begin
        wr_en = 1'b1;
      end
      csr_pkg::op_set, csr_pkg::op_clear: begin
        // x0 or zimm 0 means read only.
        wr_en = (rs1_field != 5'd0);
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/csr_exec.sv */
`timescale 1ns/1ps

module csr_exec (
  input  csr_pkg::csr_op_e                op,
  input  logic [csr_pkg::xlen-1:0]        operand,
  input  logic [csr_pkg::csr_addr_w-1:0]  csr_addr,
  input  logic                            wr_en,
  input  logic [csr_pkg::xlen-1:0]        old_data,
  input  logic [csr_pkg::xlen-1:0]        mstatus,
  input  logic [csr_pkg::xlen-1:0]        mepc,
  input  logic [csr_pkg::xlen-1:0]        mtvec,
  input  logic [csr_pkg::xlen-1:0]        pc,
  output logic                            wr1_en,
  output logic [csr_pkg::csr_addr_w-1:0]  wr1_addr,
  output logic [csr_pkg::xlen-1:0]        wr1_data,
  output logic                            wr2_en,
  output logic [csr_pkg::csr_addr_w-1:0]  wr2_addr,
  output logic [csr_pkg::xlen-1:0]        wr2_data,
  output logic                            mstatus_en,
  output logic [csr_pkg::xlen-1:0]        mstatus_next,
  output logic                            redirect_en,
  output logic [csr_pkg::xlen-1:0]        redirect_target
);

  logic [csr_pkg::xlen-1:0] csr_result;

  // zicsr read-modify-write.
  always_comb begin
    case (op)
      csr_pkg::op_set: begin
        csr_result = old_data | operand;
      end
      csr_pkg::op_clear: begin
        csr_result = old_data & ~operand;
      end
      default: begin
        csr_result = operand;
      end
    endcase
  end

  // write ports and trap state --------------
  always_comb begin
    wr1_en          = 1'b0;
    wr1_addr        = csr_addr;
    wr1_data        = csr_result;
    wr2_en          = 1'b0;
    wr2_addr        = csr_pkg::csr_mcause;
    wr2_data        = csr_pkg::mcause_ecall_m;
    mstatus_en      = 1'b0;
    mstatus_next    = mstatus;
    redirect_en     = 1'b0;
    redirect_target = mtvec;
    case (op)
      csr_pkg::op_rw, csr_pkg::op_set, csr_pkg::op_clear: begin
        wr1_en = wr_en;
      end
      csr_pkg::op_ecall: begin
        // save pc, record the cause, jump to the handler.
        wr1_en   = 1'b1;
        wr1_addr = csr_pkg::csr_mepc;
        wr1_data = pc;
        wr2_en   = 1'b1;
        mstatus_en = 1'b1;
        mstatus_next[csr_pkg::mstatus_mpie_bit] = mstatus[csr_pkg::mstatus_mie_bit];
        mstatus_next[csr_pkg::mstatus_mie_bit]  = 1'b0;
        redirect_en     = 1'b1;
        redirect_target = mtvec;
      end
      csr_pkg::op_mret: begin
        mstatus_en = 1'b1;
        mstatus_next[csr_pkg::mstatus_mie_bit]  = mstatus[csr_pkg::mstatus_mpie_bit];
        mstatus_next[csr_pkg::mstatus_mpie_bit] = 1'b1;
        redirect_en     = 1'b1;
        redirect_target = mepc;
      end
      default: begin
      end
    endcase
  end

endmodule

/* rtl/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
  parameter logic [csr_pkg::xlen-1:0] mvendorid_val = '0,
  parameter logic [csr_pkg::xlen-1:0] marchid_val   = '0,
  parameter logic [csr_pkg::xlen-1:0] mtvec_reset   = '0
) (
  input  logic                            clk,
  input  logic                            rst,
  input  csr_pkg::csr_op_e                op,
  input  logic [csr_pkg::csr_addr_w-1:0]  csr_addr,
  input  logic [4:0]                      rd_addr,
  input  logic                            wr_en,
  input  logic                            wr1_en,
  input  logic [csr_pkg::csr_addr_w-1:0]  wr1_addr,
  input  logic [csr_pkg::xlen-1:0]        wr1_data,
  input  logic                            wr2_en,
  input  logic [csr_pkg::csr_addr_w-1:0]  wr2_addr,
  input  logic [csr_pkg::xlen-1:0]        wr2_data,
  input  logic                            mstatus_en,
  input  logic [csr_pkg::xlen-1:0]        mstatus_next,
  input  logic                            redirect_en,
  input  logic [csr_pkg::xlen-1:0]        redirect_target,
  output logic [csr_pkg::xlen-1:0]        old_data,
  output logic [csr_pkg::xlen-1:0]        mstatus,
  output logic [csr_pkg::xlen-1:0]        mepc,
  output logic [csr_pkg::xlen-1:0]        mtvec,
  output logic                            rd_valid,
  output logic [4:0]                      rd_addr_q,
  output logic [csr_pkg::xlen-1:0]        rd_data,
  output logic                            redirect_valid,
  output logic [csr_pkg::xlen-1:0]        redirect_pc,
  output logic                            illegal
);

  logic [csr_pkg::xlen-1:0] mstatus_q;
  logic [csr_pkg::xlen-1:0] mcause_q;
  logic [csr_pkg::xlen-1:0] mepc_q;
  logic [csr_pkg::xlen-1:0] mtvec_q;
  logic is_csr_op;
  logic addr_known;
  logic read_only_wr;
  logic illegal_now;
  logic wr1_ok;
  logic wr2_ok;

  assign mstatus = mstatus_q | csr_pkg::mstatus_mpp_m;
  assign mepc    = mepc_q;
  assign mtvec   = mtvec_q;

  // read mux --------------
  always_comb begin
    addr_known = 1'b1;
    case (csr_addr)
      csr_pkg::csr_mstatus:   old_data = mstatus;
      csr_pkg::csr_mtvec:     old_data = mtvec_q;
      csr_pkg::csr_mepc:      old_data = mepc_q;
      csr_pkg::csr_mcause:    old_data = mcause_q;
      csr_pkg::csr_mvendorid: old_data = mvendorid_val;
      csr_pkg::csr_marchid:   old_data = marchid_val;
      default: begin
        addr_known = 1'b0;
        old_data   = '0;
      end
    endcase
  end

  // legality only applies to zicsr accesses.
  assign is_csr_op = (op == csr_pkg::op_rw) || (op == csr_pkg::op_set) ||
                     (op == csr_pkg::op_clear);
  assign read_only_wr = wr_en && (csr_addr[11:10] == 2'b11);
  assign illegal_now  = is_csr_op && (!addr_known || read_only_wr);
  assign wr1_ok = wr1_en && !illegal_now;
  assign wr2_ok = wr2_en && !illegal_now;

  // csr state --------------
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mcause_q  <= '0;
      mepc_q    <= '0;
      mtvec_q   <= {mtvec_reset[csr_pkg::xlen-1:2], 2'b00};
    end else begin
      if (mstatus_en) begin
        mstatus_q <= mstatus_next & csr_pkg::mstatus_wmask;
      end else if (wr1_ok && wr1_addr == csr_pkg::csr_mstatus) begin
        mstatus_q <= wr1_data & csr_pkg::mstatus_wmask;
      end
      if (wr2_ok && wr2_addr == csr_pkg::csr_mcause) begin
        mcause_q <= wr2_data;
      end else if (wr1_ok && wr1_addr == csr_pkg::csr_mcause) begin
        mcause_q <= wr1_data;
      end
      if (wr1_ok && wr1_addr == csr_pkg::csr_mepc) begin
        mepc_q <= wr1_data;
      end
      // direct mode only.
      if (wr1_ok && wr1_addr == csr_pkg::csr_mtvec) begin
        mtvec_q <= {wr1_data[csr_pkg::xlen-1:2], 2'b00};
      end
    end
  end

  // result pulses, one cycle after the instruction.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid       <= 1'b0;
      redirect_valid <= 1'b0;
      illegal        <= 1'b0;
    end else begin
      rd_valid       <= is_csr_op && !illegal_now;
      redirect_valid <= redirect_en;
      illegal        <= illegal_now;
    end
  end

  always_ff @(posedge clk) begin
    rd_addr_q   <= rd_addr;
    rd_data     <= old_data;
    redirect_pc <= redirect_target;
  end

  a_mtvec_aligned: assert property (@(posedge clk) disable iff (rst)
    mtvec_q[1:0] == 2'b00);

  a_one_pulse: assert property (@(posedge clk) disable iff (rst)
    $onehot0({rd_valid, redirect_valid, illegal}));

endmodule

/* rtl/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit #(
  parameter logic [csr_pkg::xlen-1:0] mvendorid_val = 32'h0000_0000,
  parameter logic [csr_pkg::xlen-1:0] marchid_val   = 32'h0000_0021,
  parameter logic [csr_pkg::xlen-1:0] mtvec_reset   = 32'h0000_0100
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_valid,
  input  logic [31:0]               instr,
  input  logic [csr_pkg::xlen-1:0]  rs1_data,
  input  logic [csr_pkg::xlen-1:0]  pc,
  output logic                      rd_valid,
  output logic [4:0]                rd_addr,
  output logic [csr_pkg::xlen-1:0]  rd_data,
  output logic                      redirect_valid,
  output logic [csr_pkg::xlen-1:0]  redirect_pc,
  output logic                      illegal
);

  csr_pkg::csr_op_e               op;
  logic [csr_pkg::xlen-1:0]       operand;
  logic [csr_pkg::csr_addr_w-1:0] csr_addr;
  logic [4:0]                     dec_rd_addr;
  logic                           wr_en;
  logic [csr_pkg::xlen-1:0]       old_data;
  logic [csr_pkg::xlen-1:0]       mstatus;
  logic [csr_pkg::xlen-1:0]       mepc;
  logic [csr_pkg::xlen-1:0]       mtvec;
  logic                           wr1_en;
  logic [csr_pkg::csr_addr_w-1:0] wr1_addr;
  logic [csr_pkg::xlen-1:0]       wr1_data;
  logic                           wr2_en;
  logic [csr_pkg::csr_addr_w-1:0] wr2_addr;
  logic [csr_pkg::xlen-1:0]       wr2_data;
  logic                           mstatus_en;
  logic [csr_pkg::xlen-1:0]       mstatus_next;
  logic                           redirect_en;
  logic [csr_pkg::xlen-1:0]       redirect_target;

  csr_decode decode_i (
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .op          (op),
    .operand     (operand),
    .csr_addr    (csr_addr),
    .rd_addr     (dec_rd_addr),
    .wr_en       (wr_en)
  );

  csr_exec exec_i (
    .op              (op),
    .operand         (operand),
    .csr_addr        (csr_addr),
    .wr_en           (wr_en),
    .old_data        (old_data),
    .mstatus         (mstatus),
    .mepc            (mepc),
    .mtvec           (mtvec),
    .pc              (pc),
    .wr1_en          (wr1_en),
    .wr1_addr        (wr1_addr),
    .wr1_data        (wr1_data),
    .wr2_en          (wr2_en),
    .wr2_addr        (wr2_addr),
    .wr2_data        (wr2_data),
    .mstatus_en      (mstatus_en),
    .mstatus_next    (mstatus_next),
    .redirect_en     (redirect_en),
    .redirect_target (redirect_target)
  );

  csr_file #(
    .mvendorid_val (mvendorid_val),
    .marchid_val   (marchid_val),
    .mtvec_reset   (mtvec_reset)
  ) file_i (
    .clk             (clk),
    .rst             (rst),
    .op              (op),
    .csr_addr        (csr_addr),
    .rd_addr         (dec_rd_addr),
    .wr_en           (wr_en),
    .wr1_en          (wr1_en),
    .wr1_addr        (wr1_addr),
    .wr1_data        (wr1_data),
    .wr2_en          (wr2_en),
    .wr2_addr        (wr2_addr),
    .wr2_data        (wr2_data),
    .mstatus_en      (mstatus_en),
    .mstatus_next    (mstatus_next),
    .redirect_en     (redirect_en),
    .redirect_target (redirect_target),
    .old_data        (old_data),
    .mstatus         (mstatus),
    .mepc            (mepc),
    .mtvec           (mtvec),
    .rd_valid        (rd_valid),
    .rd_addr_q       (rd_addr),
    .rd_data         (rd_data),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc),
    .illegal         (illegal)
  );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst
);

  // 20 ns period.
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* testbench/csr_checker.sv */
`timescale 1ns/1ps

module csr_checker #(
  parameter logic [31:0] mvendorid_val = '0,
  parameter logic [31:0] marchid_val   = '0,
  parameter logic [31:0] mtvec_reset   = '0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] rs1_data,
  input  logic [31:0] pc,
  input  logic        rd_valid,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data,
  input  logic        redirect_valid,
  input  logic [31:0] redirect_pc,
  input  logic        illegal,
  input  logic        report,
  output int          error_count,
  output logic        busy
);

  // reference csr state.
  logic        m_mie;
  logic        m_mpie;
  logic [31:0] m_mcause;
  logic [31:0] m_mepc;
  logic [31:0] m_mtvec;

  // result expected at the next edge.
  logic        exp_rd;
  logic        exp_redir;
  logic        exp_ill;
  logic [4:0]  exp_rd_addr;
  logic [31:0] exp_rd_data;
  logic [31:0] exp_redir_pc;
  logic        armed;
  int          checks;

  initial begin
    error_count = 0;
    checks      = 0;
    armed       = 1'b0;
    exp_rd      = 1'b0;
    exp_redir   = 1'b0;
    exp_ill     = 1'b0;
  end

  assign busy = exp_rd || exp_redir || exp_ill;

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    logic [31:0] ms;
    ms = 32'h0000_1800;
    ms[3] = m_mie;
    ms[7] = m_mpie;
    case (addr)
      csr_pkg::csr_mstatus:   model_read = ms;
      csr_pkg::csr_mtvec:     model_read = m_mtvec;
      csr_pkg::csr_mepc:      model_read = m_mepc;
      csr_pkg::csr_mcause:    model_read = m_mcause;
      csr_pkg::csr_mvendorid: model_read = mvendorid_val;
      csr_pkg::csr_marchid:   model_read = marchid_val;
      default:                model_read = '0;
    endcase
  endfunction

  function automatic logic model_known(input logic [11:0] addr);
    model_known = addr == csr_pkg::csr_mstatus || addr == csr_pkg::csr_mtvec ||
                  addr == csr_pkg::csr_mepc || addr == csr_pkg::csr_mcause ||
                  addr == csr_pkg::csr_mvendorid || addr == csr_pkg::csr_marchid;
  endfunction

  task automatic check_pulse(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      error_count++;
      if (expected) begin
        $display("%0t: missing %s pulse", $time, name);
      end else begin
        $display("%0t: unexpected %s pulse", $time, name);
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic compare_outputs();
    checks++;
    check_pulse("rd_valid", rd_valid, exp_rd);
    check_pulse("redirect_valid", redirect_valid, exp_redir);
    check_pulse("illegal", illegal, exp_ill);
    if (exp_rd && rd_valid === 1'b1) begin
      check_value("rd_addr", {27'd0, rd_addr}, {27'd0, exp_rd_addr});
      check_value("rd_data", rd_data, exp_rd_data);
    end
    if (exp_redir && redirect_valid === 1'b1) begin
      check_value("redirect_pc", redirect_pc, exp_redir_pc);
    end
  endtask

  // model step for the instruction at this edge.
  task automatic predict();
    logic [2:0]  f3;
    logic [11:0] addr;
    logic [4:0]  rs1f;
    logic [31:0] operand;
    logic [31:0] old_val;
    logic [31:0] new_val;
    logic        write_req;
    f3        = instr[14:12];
    addr      = instr[31:20];
    rs1f      = instr[19:15];
    operand   = f3[2] ? {27'd0, rs1f} : rs1_data;
    old_val   = model_read(addr);
    write_req = (f3[1:0] == 2'b01) || (rs1f != 5'd0);
    exp_rd    = 1'b0;
    exp_redir = 1'b0;
    exp_ill   = 1'b0;
    if (instr_valid && instr[6:0] == csr_pkg::opcode_system) begin
      if (f3[1:0] != 2'b00) begin
        if (!model_known(addr) || (write_req && addr[11:10] == 2'b11)) begin
          exp_ill = 1'b1;
        end else begin
          exp_rd      = 1'b1;
          exp_rd_addr = instr[11:7];
          exp_rd_data = old_val;
          case (f3[1:0])
            2'b01:   new_val = operand;
            2'b10:   new_val = old_val | operand;
            default: new_val = old_val & ~operand;
          endcase
          if (write_req) begin
            case (addr)
              csr_pkg::csr_mstatus: begin
                m_mie  = new_val[3];
                m_mpie = new_val[7];
              end
              csr_pkg::csr_mtvec:  m_mtvec = {new_val[31:2], 2'b00};
              csr_pkg::csr_mepc:   m_mepc = new_val;
              csr_pkg::csr_mcause: m_mcause = new_val;
              default: begin
              end
            endcase
          end
        end
      end else if (instr == csr_pkg::insn_ecall) begin
        exp_redir    = 1'b1;
        exp_redir_pc = m_mtvec;
        m_mepc       = pc;
        m_mcause     = 32'd11;
        m_mpie       = m_mie;
        m_mie        = 1'b0;
      end else if (instr == csr_pkg::insn_mret) begin
        exp_redir    = 1'b1;
        exp_redir_pc = m_mepc;
        m_mie        = m_mpie;
        m_mpie       = 1'b1;
      end
    end
  endtask

  always @(posedge clk) begin
    if (armed) begin
      compare_outputs();
    end
    if (rst) begin
      m_mie     = 1'b0;
      m_mpie    = 1'b0;
      m_mcause  = '0;
      m_mepc    = '0;
      m_mtvec   = {mtvec_reset[31:2], 2'b00};
      exp_rd    = 1'b0;
      exp_redir = 1'b0;
      exp_ill   = 1'b0;
      armed     = 1'b1;
    end else begin
      predict();
    end
  end

  always @(posedge report) begin
    $display("csr_checker: %0d cycles compared, %0d errors", checks, error_count);
  end

endmodule

/* testbench/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb;

  localparam logic [31:0] vendor_id  = 32'h0000_0b1e;
  localparam logic [31:0] arch_id    = 32'h0000_0a5c;
  localparam logic [31:0] mtvec_init = 32'h0000_0207;
  localparam int          num_insns  = 2000;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] rs1_data;
  logic [31:0] pc;
  logic        rd_valid;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        illegal;
  logic        report;
  logic        busy;
  logic        timed_out;
  int          error_count;

  tb_clock clock_i (
    .clk (clk),
    .rst (rst)
  );

  csr_unit #(
    .mvendorid_val (vendor_id),
    .marchid_val   (arch_id),
    .mtvec_reset   (mtvec_init)
  ) csr_unit_i (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .rs1_data       (rs1_data),
    .pc             (pc),
    .rd_valid       (rd_valid),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .illegal        (illegal)
  );

  csr_checker #(
    .mvendorid_val (vendor_id),
    .marchid_val   (arch_id),
    .mtvec_reset   (mtvec_init)
  ) checker_i (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .rs1_data       (rs1_data),
    .pc             (pc),
    .rd_valid       (rd_valid),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .illegal        (illegal),
    .report         (report),
    .error_count    (error_count),
    .busy           (busy)
  );

  function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] addr,
                                           input logic [4:0] rs1f, input logic [4:0] rd);
    csr_word = {addr, rs1f, f3, rd, csr_pkg::opcode_system};
  endfunction

  // writable, read-only and unimplemented addresses.
  function automatic logic [11:0] pick_addr();
    int r;
    r = $urandom_range(0, 9);
    case (r)
      0: pick_addr = csr_pkg::csr_mstatus;
      1, 2: pick_addr = csr_pkg::csr_mtvec;
      3: pick_addr = csr_pkg::csr_mepc;
      4, 5: pick_addr = csr_pkg::csr_mcause;
      6: pick_addr = csr_pkg::csr_mvendorid;
      7: pick_addr = csr_pkg::csr_marchid;
      8: pick_addr = {4'h3, 8'($urandom())};
      default: pick_addr = 12'($urandom());
    endcase
  endfunction

  function automatic logic [31:0] random_insn();
    int          r;
    logic [2:0]  f3;
    logic [4:0]  rs1f;
    logic [31:0] w;
    r = $urandom_range(0, 19);
    case ($urandom_range(0, 5))
      0: f3 = 3'b001;
      1: f3 = 3'b010;
      2: f3 = 3'b011;
      3: f3 = 3'b101;
      4: f3 = 3'b110;
      default: f3 = 3'b111;
    endcase
    rs1f = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom());
    w = $urandom();
    if (r < 14) begin
      random_insn = csr_word(f3, pick_addr(), rs1f, 5'($urandom()));
    end else if (r < 16) begin
      random_insn = csr_pkg::insn_ecall;
    end else if (r < 18) begin
      random_insn = csr_pkg::insn_mret;
    end else begin
      // anything but the system opcode.
      if (w[6:0] == csr_pkg::opcode_system) begin
        w[4] = 1'b0;
      end
      random_insn = w;
    end
  endfunction

  task automatic issue(input logic [31:0] word);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= word;
    rs1_data    <= $urandom();
    pc          <= $urandom() & 32'hffff_fffc;
  endtask

  // idle cycles carry junk on instr.
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      instr       <= $urandom();
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("timeout: results did not drain after the last instruction");
      timed_out = 1'b1;
    end
  endtask

  // stimulus --------------
  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    rs1_data    = '0;
    pc          = '0;
    report      = 1'b0;
    timed_out   = 1'b0;
    void'($urandom(38021));
    wait_reset_release();
    if (!timed_out) begin
      // reset values through csrrs with x0.
      issue(csr_word(3'b010, csr_pkg::csr_mstatus, 5'd0, 5'd1));
      issue(csr_word(3'b010, csr_pkg::csr_mtvec, 5'd0, 5'd2));
      issue(csr_word(3'b010, csr_pkg::csr_mepc, 5'd0, 5'd3));
      issue(csr_word(3'b010, csr_pkg::csr_mcause, 5'd0, 5'd4));
      issue(csr_word(3'b010, csr_pkg::csr_mvendorid, 5'd0, 5'd5));
      issue(csr_word(3'b010, csr_pkg::csr_marchid, 5'd0, 5'd6));
      for (int i = 0; i < num_insns; i++) begin
        issue(random_insn());
        if ($urandom_range(0, 2) == 0) begin
          idle($urandom_range(1, 3));
        end
      end
      idle(1);
      wait_drain();
    end
    report = 1'b1;
    #1;
    if (timed_out || error_count != 0) begin
      $display("Verification failed");
    end else begin
      $display("Verification passed");
    end
    $finish;
  end

endmodule

/* project.f */
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_exec.sv
rtl/csr_file.sv
rtl/csr_unit.sv
testbench/tb_clock.sv
testbench/csr_checker.sv
testbench/csr_unit_tb.sv

/* Makefile */
TOP = csr_unit_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Verification passed'

clean:
	rm -rf obj_dir
